// ==== sim.f ====
rtl/burst_pkg.sv
rtl/req_arbiter.sv
rtl/burst_issue.sv
rtl/fill_return.sv
rtl/mem_burst_bridge.sv
testbench/burst_mem_model.sv
testbench/tb_mem_burst_bridge.sv

// ==== Bender.yml ====
package:
  name: mem_burst_bridge

sources:
  - rtl/burst_pkg.sv
  - rtl/req_arbiter.sv
  - rtl/burst_issue.sv
  - rtl/fill_return.sv
  - rtl/mem_burst_bridge.sv
  - target: test
    files:
      - testbench/burst_mem_model.sv
      - testbench/tb_mem_burst_bridge.sv

// ==== testbench/tb_mem_burst_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_burst_bridge;

    localparam int NUM_ROWS = 6;
    localparam int CYCLE_LIMIT = 200 * NUM_ROWS + 20;
    localparam burst_pkg::beat_t FILL_PATTERN = 64'h3c5a_96e1_0f87_d2b4;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic i_req_valid, d_req_valid, d_write;
    burst_pkg::addr_t i_addr, d_addr, bmem_addr;
    burst_pkg::line_t d_wline, i_line, d_line;
    logic i_req_ready, i_resp_valid, d_req_ready, d_resp_valid;
    logic bmem_read, bmem_write, bmem_ready, bmem_rvalid;
    burst_pkg::beat_t bmem_wdata, bmem_rdata;

    // stimulus table, port 1 means data side
    logic              row_port  [NUM_ROWS];
    burst_pkg::addr_t  row_addr  [NUM_ROWS];
    logic              row_write [NUM_ROWS];
    burst_pkg::line_t  row_wline [NUM_ROWS];
    logic              row_pair  [NUM_ROWS];   // presented with the next row

    burst_pkg::line_t  written [burst_pkg::addr_t];
    burst_pkg::addr_t  cmd_q[$];
    int errors = 0;
    int tests = 0;
    int cycles = 0;
    int wr_beats = 0;
    logic outstanding = 1'b0;

    always #10 clk = ~clk;

    mem_burst_bridge u_dut (
        .clk (clk), .rst (rst),
        .i_req_valid_i (i_req_valid), .i_addr_i (i_addr),
        .i_req_ready_o (i_req_ready), .i_line_o (i_line), .i_resp_valid_o (i_resp_valid),
        .d_req_valid_i (d_req_valid), .d_addr_i (d_addr), .d_write_i (d_write),
        .d_wline_i (d_wline), .d_req_ready_o (d_req_ready), .d_line_o (d_line),
        .d_resp_valid_o (d_resp_valid),
        .bmem_addr_o (bmem_addr), .bmem_read_o (bmem_read), .bmem_write_o (bmem_write),
        .bmem_wdata_o (bmem_wdata), .bmem_ready_i (bmem_ready),
        .bmem_rdata_i (bmem_rdata), .bmem_rvalid_i (bmem_rvalid)
    );

    burst_mem_model u_mem (
        .clk (clk), .rst (rst), .addr_i (bmem_addr), .read_i (bmem_read),
        .write_i (bmem_write), .wdata_i (bmem_wdata), .ready_o (bmem_ready),
        .rdata_o (bmem_rdata), .rvalid_o (bmem_rvalid)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: no response after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic burst_pkg::addr_t align(input burst_pkg::addr_t a);
        return a & ~burst_pkg::addr_t'(31);
    endfunction

    // initial memory content unless the line was written
    function automatic burst_pkg::line_t expected_line(input burst_pkg::addr_t a);
        burst_pkg::line_t l;
        burst_pkg::addr_t base;
        base = align(a);
        if (written.exists(base)) begin
            return written[base];
        end
        for (int b = 0; b < 4; b++) begin
            l[b*64 +: 64] = burst_pkg::beat_t'(base + burst_pkg::addr_t'(8 * b)) ^ FILL_PATTERN;
        end
        return l;
    endfunction

    task automatic check_line(input string what, input burst_pkg::line_t got,
                              input burst_pkg::line_t exp);
        tests++;
        if (got !== exp) begin
            errors++;
            $display("FAILED @ %0t: %s line %h, expected %h", $time, what, got, exp);
        end else begin
            $display("ok   %s", what);
        end
    endtask

    task automatic check_addr(input string what, input burst_pkg::addr_t got,
                              input burst_pkg::addr_t exp);
        tests++;
        if (got !== exp) begin
            errors++;
            $display("FAILED @ %0t: %s address %h, expected %h", $time, what, got, exp);
        end else begin
            $display("ok   %s", what);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        tests++;
        if (got !== exp) begin
            errors++;
            $display("FAILED @ %0t: %s is %b, expected %b", $time, what, got, exp);
        end else begin
            $display("ok   %s", what);
        end
    endtask

    task automatic load_table();
        row_port  = '{0, 1, 1, 0, 1, 0};
        row_addr  = '{32'h0000_1000, 32'h0000_2047, 32'h0000_3000,
                      32'h0000_3000, 32'h0000_4000, 32'h0000_5010};
        row_write = '{0, 0, 1, 0, 0, 0};
        row_pair  = '{0, 0, 0, 0, 1, 0};
        for (int r = 0; r < NUM_ROWS; r++) begin
            row_wline[r] = '0;
        end
        row_wline[2] = {128'hdead_beef_0123_4567_89ab_cdef_fedc_ba98,
                        128'h7654_3210_a5a5_5a5a_1111_2222_3333_4444};
    endtask

    // one response from a port, command address and line checked
    task automatic take_resp(input int r);
        burst_pkg::addr_t cmd;
        cmd = cmd_q.size() > 0 ? cmd_q.pop_front() : 'x;
        check_addr($sformatf("row %0d command", r), cmd, align(row_addr[r]));
        if (row_write[r]) begin
            written[align(row_addr[r])] = row_wline[r];
            $display("ok   row %0d write acknowledged", r);
        end else if (row_port[r]) begin
            check_line($sformatf("row %0d data read", r), d_line, expected_line(row_addr[r]));
        end else begin
            check_line($sformatf("row %0d instr read", r), i_line, expected_line(row_addr[r]));
        end
    endtask

    task automatic run_group(input int first, input int count);
        int idx_i;
        int idx_d;
        int pend;
        int first_port;
        logic acc_i;
        logic acc_d;
        logic resp_seen;
        logic back_due;
        logic back_ok;
        idx_i = -1;
        idx_d = -1;
        first_port = -1;
        pend = count;
        resp_seen = 1'b0;
        back_due = 1'b0;
        for (int r = first; r < first + count; r++) begin
            if (row_port[r]) idx_d = r;
            else idx_i = r;
        end
        @(negedge clk);
        if (idx_i >= 0) begin
            i_req_valid = 1'b1;
            i_addr = row_addr[idx_i];
        end
        if (idx_d >= 0) begin
            d_req_valid = 1'b1;
            d_addr  = row_addr[idx_d];
            d_write = row_write[idx_d];
            d_wline = row_wline[idx_d];
        end
        while (pend > 0 || resp_seen || back_due) begin
            #1;
            if (outstanding && (i_req_ready || d_req_ready)) begin
                errors++;
                $display("request ready went high while a request was outstanding");
            end
            if (resp_seen) begin
                // pulse cycle, readies still held low
                outstanding = 1'b0;
                resp_seen = 1'b0;
                back_due = 1'b1;
            end else if (back_due) begin
                // a waiting port gets its ready back, otherwise both are up
                if (i_req_valid || d_req_valid) begin
                    back_ok = (i_req_valid && i_req_ready) || (d_req_valid && d_req_ready);
                end else begin
                    back_ok = i_req_ready && d_req_ready;
                end
                check_flag("ready back after the response", back_ok, 1'b1);
                back_due = 1'b0;
            end
            acc_i = i_req_valid && i_req_ready;
            acc_d = d_req_valid && d_req_ready;
            if (acc_i || acc_d) outstanding = 1'b1;
            if (bmem_read || (bmem_write && wr_beats == 0)) cmd_q.push_back(bmem_addr);
            if (bmem_write) wr_beats = (wr_beats + 1) % 4;
            @(negedge clk);
            if (acc_i) i_req_valid = 1'b0;
            if (acc_d) d_req_valid = 1'b0;
            if (i_resp_valid && d_resp_valid) begin
                errors++;
                $display("both response valids pulsed in the same cycle");
            end
            if (i_resp_valid || d_resp_valid) begin
                if ((i_resp_valid ? idx_i : idx_d) < 0) begin
                    errors++;
                    $display("response pulsed on a port with no request");
                end else begin
                    take_resp(i_resp_valid ? idx_i : idx_d);
                end
                if (first_port < 0) first_port = d_resp_valid;
                resp_seen = 1'b1;
                pend--;
            end
        end
        if (count == 2) check_flag("data side served first", first_port == 1, 1'b1);
    endtask

    initial begin
        int k;
        i_req_valid = 1'b0;
        d_req_valid = 1'b0;
        d_write = 1'b0;
        i_addr  = '0;
        d_addr  = '0;
        d_wline = '0;
        load_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_flag("i ready after reset", i_req_ready, 1'b1);
        check_flag("d ready after reset", d_req_ready, 1'b1);
        check_flag("no memory command after reset", bmem_read || bmem_write, 1'b0);
        check_flag("no response after reset", i_resp_valid || d_resp_valid, 1'b0);
        k = 0;
        while (k < NUM_ROWS) begin
            if (row_pair[k]) begin
                run_group(k, 2);
                k = k + 2;
            end else begin
                run_group(k, 1);
                k = k + 1;
            end
        end
        $display("%0d checks, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_mem_burst_bridge

`default_nettype wire

// ==== testbench/burst_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_mem_model (
    input  wire                      clk,
    input  wire                      rst,
    input  wire burst_pkg::addr_t    addr_i,
    input  wire                      read_i,
    input  wire                      write_i,
    input  wire burst_pkg::beat_t    wdata_i,
    output logic                     ready_o,
    output burst_pkg::beat_t         rdata_o,
    output logic                     rvalid_o
);

    localparam burst_pkg::beat_t FILL_PATTERN = 64'h3c5a_96e1_0f87_d2b4;

    burst_pkg::beat_t      mem [burst_pkg::addr_t];   // only written words
    logic                  live = 1'b0;               // out of reset at the last rising edge
    logic                  pend;                      // read burst under way
    burst_pkg::addr_t      raddr;
    int                    wait_cnt;                  // cycles before first beat, -1 until drawn
    int                    rbeat;
    burst_pkg::beat_idx_t  wbeat;

    function automatic burst_pkg::beat_t word_at(input burst_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return burst_pkg::beat_t'(a) ^ FILL_PATTERN;
    endfunction

    // commands and write beats are taken on the rising edge
    always @(posedge clk) begin
        live = !rst;
        if (rst) begin
            pend  = 1'b0;
            wbeat = '0;
        end else begin
            if (read_i && ready_o) begin
                pend     = 1'b1;
                raddr    = addr_i;
                wait_cnt = -1;
                rbeat    = 0;
            end
            if (write_i) begin
                mem[addr_i + burst_pkg::addr_t'(8 * wbeat)] = wdata_i;
                wbeat = wbeat + burst_pkg::beat_idx_t'(1);
            end
        end
    end

    // outputs change on the falling edge
    initial begin
        void'($urandom(32'h8c3a));   // one stream for ready, latency and gaps
        forever begin
            @(negedge clk);
            if (!live) begin
                ready_o  <= 1'b0;
                rvalid_o <= 1'b0;
                rdata_o  <= '0;
            end else begin
                ready_o  <= ($urandom % 4) != 0;
                rvalid_o <= 1'b0;
                if (pend) begin
                    if (wait_cnt < 0) begin
                        wait_cnt = $urandom % 4;
                    end
                    if (wait_cnt > 0) begin
                        wait_cnt = wait_cnt - 1;
                    end else if (($urandom % 3) != 0) begin   // gaps between beats
                        rvalid_o <= 1'b1;
                        rdata_o  <= word_at(raddr + burst_pkg::addr_t'(8 * rbeat));
                        rbeat = rbeat + 1;
                        if (rbeat == 4) begin
                            pend = 1'b0;
                        end
                    end
                end
            end
        end
    end

endmodule : burst_mem_model

`default_nettype wire

// ==== rtl/mem_burst_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_burst_bridge (
    input  wire                      clk,
    input  wire                      rst,

    // instruction side
    input  wire                      i_req_valid_i,
    input  wire burst_pkg::addr_t    i_addr_i,
    output logic                     i_req_ready_o,
    output burst_pkg::line_t         i_line_o,
    output logic                     i_resp_valid_o,

    // data side
    input  wire                      d_req_valid_i,
    input  wire burst_pkg::addr_t    d_addr_i,
    input  wire                      d_write_i,
    input  wire burst_pkg::line_t    d_wline_i,
    output logic                     d_req_ready_o,
    output burst_pkg::line_t         d_line_o,
    output logic                     d_resp_valid_o,

    // burst memory
    output burst_pkg::addr_t         bmem_addr_o,
    output logic                     bmem_read_o,
    output logic                     bmem_write_o,
    output burst_pkg::beat_t         bmem_wdata_o,
    input  wire                      bmem_ready_i,
    input  wire burst_pkg::beat_t    bmem_rdata_i,
    input  wire                      bmem_rvalid_i
);

    logic                 req_valid;
    logic                 req_ready;
    burst_pkg::req_src_e  req_src;
    burst_pkg::addr_t     req_addr;
    logic                 req_write;
    burst_pkg::line_t     req_wline;
    burst_pkg::req_src_e  rd_src;
    logic                 wr_done;
    logic                 line_done;
    logic                 busy;
    logic                 req_taken;

    assign req_taken = req_valid && req_ready;   // arbiter to issue handoff

    req_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .i_req_valid_i (i_req_valid_i),
        .i_addr_i      (i_addr_i),
        .d_req_valid_i (d_req_valid_i),
        .d_addr_i      (d_addr_i),
        .d_write_i     (d_write_i),
        .d_wline_i     (d_wline_i),
        .busy_i        (busy),
        .i_req_ready_o (i_req_ready_o),
        .d_req_ready_o (d_req_ready_o),
        .req_valid_o   (req_valid),
        .req_src_o     (req_src),
        .req_addr_o    (req_addr),
        .req_write_o   (req_write),
        .req_wline_o   (req_wline)
    );

    burst_issue u_issue (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_src_i    (req_src),
        .req_addr_i   (req_addr),
        .req_write_i  (req_write),
        .req_wline_i  (req_wline),
        .req_ready_o  (req_ready),
        .bmem_ready_i (bmem_ready_i),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .line_done_i  (line_done),
        .rd_src_o     (rd_src),
        .wr_done_o    (wr_done)
    );

    fill_return u_return (
        .clk            (clk),
        .rst            (rst),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i),
        .rd_src_i       (rd_src),
        .wr_done_i      (wr_done),
        .req_taken_i    (req_taken),
        .line_done_o    (line_done),
        .i_line_o       (i_line_o),
        .d_line_o       (d_line_o),
        .i_resp_valid_o (i_resp_valid_o),
        .d_resp_valid_o (d_resp_valid_o),
        .busy_o         (busy)
    );

endmodule : mem_burst_bridge

`default_nettype wire

// ==== rtl/fill_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module fill_return (
    input  wire                      clk,
    input  wire                      rst,

    input  wire burst_pkg::beat_t    bmem_rdata_i,
    input  wire                      bmem_rvalid_i,

    input  wire burst_pkg::req_src_e rd_src_i,     // owner of the read
    input  wire                      wr_done_i,    // last write beat on the bus
    input  wire                      req_taken_i,

    output logic                     line_done_o,
    output burst_pkg::line_t         i_line_o,
    output burst_pkg::line_t         d_line_o,
    output logic                     i_resp_valid_o,
    output logic                     d_resp_valid_o,
    output logic                     busy_o
);

    // beats 0..2, beat 0 ends up lowest
    logic [burst_pkg::LINE_W-burst_pkg::BEAT_W-1:0] fill_q;
    burst_pkg::beat_idx_t  beat_q;
    burst_pkg::line_t      line_in;    // full line on the last beat
    logic                  last_beat;
    logic                  last_i;
    logic                  last_d;
    logic                  resp_any;

    assign last_beat = bmem_rvalid_i &&
                       (beat_q == burst_pkg::beat_idx_t'(burst_pkg::BEATS_PER_LINE - 1));
    assign last_i    = last_beat && (rd_src_i == burst_pkg::SRC_INSTR);
    assign last_d    = last_beat && (rd_src_i == burst_pkg::SRC_DATA);
    assign line_in   = {bmem_rdata_i, fill_q};
    assign resp_any  = i_resp_valid_o || d_resp_valid_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q         <= '0;
            line_done_o    <= 1'b0;
            i_resp_valid_o <= 1'b0;
            d_resp_valid_o <= 1'b0;
            busy_o         <= 1'b0;
        end else begin
            if (bmem_rvalid_i) begin
                beat_q <= beat_q + burst_pkg::beat_idx_t'(1);
            end
            line_done_o    <= last_beat;
            i_resp_valid_o <= last_i;
            d_resp_valid_o <= last_d || wr_done_i;   // write ack shares the data port
            if (req_taken_i) begin
                busy_o <= 1'b1;
            end else if (resp_any) begin
                busy_o <= 1'b0;   // readies come back the cycle after the pulse
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            fill_q <= {bmem_rdata_i, fill_q[burst_pkg::LINE_W-burst_pkg::BEAT_W-1:burst_pkg::BEAT_W]};
        end
        // each port keeps its line until its next fill
        if (last_i) begin
            i_line_o <= line_in;
        end
        if (last_d) begin
            d_line_o <= line_in;
        end
    end

endmodule : fill_return

`default_nettype wire

// ==== rtl/burst_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_issue (
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      req_valid_i,
    input  wire burst_pkg::req_src_e req_src_i,
    input  wire burst_pkg::addr_t    req_addr_i,
    input  wire                      req_write_i,
    input  wire burst_pkg::line_t    req_wline_i,
    output logic                     req_ready_o,

    input  wire                      bmem_ready_i,
    output burst_pkg::addr_t         bmem_addr_o,
    output logic                     bmem_read_o,
    output logic                     bmem_write_o,
    output burst_pkg::beat_t         bmem_wdata_o,

    input  wire                      line_done_i,   // read line handed back
    output burst_pkg::req_src_e      rd_src_o,
    output logic                     wr_done_o
);

    burst_pkg::issue_state_e  state_q;
    burst_pkg::issue_state_e  state_d;
    burst_pkg::beat_idx_t     beat_q;     // next write beat
    burst_pkg::beat_idx_t     beat_d;
    burst_pkg::addr_t         addr_q;
    burst_pkg::req_src_e      src_q;
    burst_pkg::line_t         wline_q;
    burst_pkg::addr_t         addr_in;    // incoming address, line aligned
    logic                     take;
    logic                     last_beat;

    assign addr_in = {req_addr_i[burst_pkg::ADDR_W-1:burst_pkg::LINE_OFFSET_W],
                      {burst_pkg::LINE_OFFSET_W{1'b0}}};

    assign req_ready_o = (state_q == burst_pkg::ISSUE_IDLE);
    assign take        = req_valid_i && req_ready_o;
    assign last_beat   = (beat_q == burst_pkg::beat_idx_t'(burst_pkg::BEATS_PER_LINE - 1));
    assign rd_src_o    = src_q;

    // bus outputs
    // the idle state drives straight from the offered request so the
    // command goes out in the same cycle the request is taken
    always_comb begin
        bmem_addr_o  = addr_q;
        bmem_read_o  = 1'b0;
        bmem_write_o = 1'b0;
        bmem_wdata_o = wline_q[beat_q * burst_pkg::BEAT_W +: burst_pkg::BEAT_W];
        wr_done_o    = 1'b0;
        case (state_q)
            burst_pkg::ISSUE_IDLE: begin
                bmem_addr_o  = addr_in;
                bmem_wdata_o = req_wline_i[burst_pkg::BEAT_W-1:0];
                bmem_read_o  = take && !req_write_i && bmem_ready_i;
                bmem_write_o = take && req_write_i && bmem_ready_i;
            end
            burst_pkg::ISSUE_READ_CMD: begin
                bmem_read_o = bmem_ready_i;
            end
            burst_pkg::ISSUE_WRITE: begin
                // ready only matters for beat 0, the rest follow back to back
                bmem_write_o = (beat_q != '0) || bmem_ready_i;
                wr_done_o    = last_beat;
            end
            default: begin
            end
        endcase
    end

    // next state
    always_comb begin
        state_d = state_q;
        beat_d  = beat_q;
        case (state_q)
            burst_pkg::ISSUE_IDLE: begin
                if (take) begin
                    if (req_write_i) begin
                        state_d = burst_pkg::ISSUE_WRITE;
                        beat_d  = burst_pkg::beat_idx_t'(bmem_ready_i);   // beat 0 already out
                    end else begin
                        state_d = bmem_ready_i ? burst_pkg::ISSUE_READ_WAIT
                                               : burst_pkg::ISSUE_READ_CMD;
                    end
                end
            end
            burst_pkg::ISSUE_READ_CMD: begin
                if (bmem_ready_i) begin
                    state_d = burst_pkg::ISSUE_READ_WAIT;
                end
            end
            burst_pkg::ISSUE_READ_WAIT: begin
                if (line_done_i) begin
                    state_d = burst_pkg::ISSUE_IDLE;
                end
            end
            burst_pkg::ISSUE_WRITE: begin
                if (bmem_write_o) begin
                    beat_d = beat_q + burst_pkg::beat_idx_t'(1);   // wraps to 0 after beat 3
                    if (last_beat) begin
                        state_d = burst_pkg::ISSUE_IDLE;
                    end
                end
            end
            default: begin
                state_d = burst_pkg::ISSUE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= burst_pkg::ISSUE_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
        end
    end

    // request copy for the cycles after the take
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q  <= addr_in;
            src_q   <= req_src_i;
            wline_q <= req_wline_i;
        end
    end

endmodule : burst_issue

`default_nettype wire

// ==== rtl/req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      i_req_valid_i,
    input  wire burst_pkg::addr_t    i_addr_i,

    input  wire                      d_req_valid_i,
    input  wire burst_pkg::addr_t    d_addr_i,
    input  wire                      d_write_i,
    input  wire burst_pkg::line_t    d_wline_i,

    input  wire                      busy_i,        // response still pending

    output logic                     i_req_ready_o,
    output logic                     d_req_ready_o,

    output logic                     req_valid_o,
    output burst_pkg::req_src_e      req_src_o,
    output burst_pkg::addr_t         req_addr_o,
    output logic                     req_write_o,
    output burst_pkg::line_t         req_wline_o
);

    logic                 held_q;   // granted request sits in the register
    burst_pkg::req_src_e  last_q;   // side of the previous grant
    logic                 free;
    logic                 grant_i;
    logic                 grant_d;

    assign free = !held_q && !busy_i;

    // a port loses only when the other one is valid and has priority
    // priority flips after every grant
    assign i_req_ready_o = free && (!d_req_valid_i || last_q == burst_pkg::SRC_DATA);
    assign d_req_ready_o = free && (!i_req_valid_i || last_q == burst_pkg::SRC_INSTR);

    assign grant_i = i_req_valid_i && i_req_ready_o;
    assign grant_d = d_req_valid_i && d_req_ready_o;

    // busy rises the cycle after burst_issue takes the request
    assign req_valid_o = held_q && !busy_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q <= 1'b0;
            last_q <= burst_pkg::SRC_INSTR;   // data wins the first tie
        end else begin
            if (grant_i || grant_d) begin
                held_q <= 1'b1;
                last_q <= grant_d ? burst_pkg::SRC_DATA : burst_pkg::SRC_INSTR;
            end else if (busy_i) begin
                held_q <= 1'b0;   // request is now with burst_issue
            end
        end
    end

    // granted request payload
    always_ff @(posedge clk) begin
        if (grant_d) begin
            req_src_o   <= burst_pkg::SRC_DATA;
            req_addr_o  <= d_addr_i;
            req_write_o <= d_write_i;
            req_wline_o <= d_wline_i;
        end else if (grant_i) begin
            req_src_o   <= burst_pkg::SRC_INSTR;
            req_addr_o  <= i_addr_i;
            req_write_o <= 1'b0;   // instruction side only reads
        end
    end

endmodule : req_arbiter

`default_nettype wire

// ==== rtl/burst_pkg.sv ====
`default_nettype none

package burst_pkg;

    // memory bus and cache line geometry
    localparam int ADDR_W         = 32;
    localparam int BEAT_W         = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_W         = BEAT_W * BEATS_PER_LINE;   // 256
    localparam int LINE_OFFSET_W  = 5;                         // byte offset inside a line

    typedef logic [ADDR_W-1:0] addr_t;     // byte address
    typedef logic [BEAT_W-1:0] beat_t;     // one bus beat
    typedef logic [LINE_W-1:0] line_t;     // beat 0 in the low 64 bits
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

    // owner of the request in flight
    typedef enum logic {
        SRC_INSTR = 1'b0,
        SRC_DATA  = 1'b1
    } req_src_e;

    // burst_issue FSM
    typedef enum logic [1:0] {
        ISSUE_IDLE      = 2'd0,
        ISSUE_READ_CMD  = 2'd1,   // read taken, bus not ready yet
        ISSUE_READ_WAIT = 2'd2,   // command sent, beats coming back
        ISSUE_WRITE     = 2'd3
    } issue_state_e;

endpackage

`default_nettype wire
